//--- rtl/ejection_port.sv
// round-robin ejection sender
`default_nettype none

module ejection_port #(
	parameter int NUM_NODES = 8
) (
	input logic clk,
	input logic reset,
	input noc_pkg::link_t node_out [NUM_NODES],
	output logic [NUM_NODES-1:0] node_grant,
	output logic eject_req,
	output noc_pkg::flit_t eject_flit,
	input logic eject_ack
);

	localparam int PTR_W = $clog2(NUM_NODES);

	noc_pkg::hs_state_e state;
	logic [PTR_W-1:0] rr_ptr;
	logic [PTR_W-1:0] pick;
	logic pick_valid;
	logic take;

	// first node with a packet at or after the pointer
	always_comb
	begin
		int idx;
		pick_valid = 1'b0;
		pick = '0;
		for (int k = NUM_NODES - 1; k >= 0; k--)
		begin
			idx = (int'(rr_ptr) + k) % NUM_NODES;
			if (node_out[idx].valid)
			begin
				pick_valid = 1'b1;
				pick = PTR_W'(idx);
			end
		end
	end

	assign take = (state == noc_pkg::HS_IDLE) && pick_valid;

	always_comb
		for (int n = 0; n < NUM_NODES; n++)
			node_grant[n] = take && pick == PTR_W'(n);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= noc_pkg::HS_IDLE;
			eject_req <= 1'b0;
			rr_ptr <= '0;
		end
		else
		begin
			case (state)
				noc_pkg::HS_IDLE:
					if (take)
					begin
						eject_req <= 1'b1;
						rr_ptr <= (pick == PTR_W'(NUM_NODES - 1)) ? '0 : pick + 1'b1;
						state <= noc_pkg::HS_BUSY;
					end
				noc_pkg::HS_BUSY:
					if (eject_ack)
					begin
						eject_req <= 1'b0;
						state <= noc_pkg::HS_WAIT_LOW;
					end
				default:
					// next packet only once ack has dropped
					if (!eject_ack)
						state <= noc_pkg::HS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
		if (take)
			eject_flit <= node_out[pick].flit;

	assert property (@(posedge clk) disable iff (reset)
		eject_req |=> !eject_req || $stable(eject_flit));

endmodule

`default_nettype wire

//--- rtl/flit_fifo.sv
// link input packet buffer
`default_nettype none

module flit_fifo #(
	parameter int NUM_NODES = 8,
	parameter int FIFO_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic wr_valid,
	input noc_pkg::flit_t wr_flit,
	input logic rd_pop,
	output noc_pkg::link_t rd_head,
	output logic ready,
	output logic bubble
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	noc_pkg::flit_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_rd;

	assign do_rd = rd_pop && count != '0;
	assign ready = count < CNT_W'(FIFO_DEPTH);
	// two free slots let a packet join the ring
	assign bubble = count < CNT_W'(FIFO_DEPTH - 1);
	assign rd_head = {(count != '0), mem[rd_ptr]};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_valid)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr_valid && !do_rd)
				count <= count + 1'b1;
			else if (!wr_valid && do_rd)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
		if (wr_valid)
			mem[wr_ptr] <= wr_flit;

	// upstream must see ready before it writes, and only ring addresses arrive
	assert property (@(posedge clk) disable iff (reset)
		wr_valid |-> ready && wr_flit.dest < NUM_NODES);

endmodule

`default_nettype wire

//--- rtl/injection_port.sv
// four-phase injection receiver
`default_nettype none

module injection_port #(
	parameter int NUM_NODES = 8
) (
	input logic clk,
	input logic reset,
	input logic inject_req,
	input noc_pkg::flit_t inject_flit,
	output logic inject_ack,
	output noc_pkg::link_t local_in [NUM_NODES],
	input logic [NUM_NODES-1:0] local_ready
);

	noc_pkg::hs_state_e state;
	noc_pkg::flit_t held;
	logic [NUM_NODES-1:0] target;
	logic accepted;

	// only the source node sees the packet as valid
	always_comb
	begin
		for (int n = 0; n < NUM_NODES; n++)
		begin
			target[n] = (held.src == noc_pkg::node_id_t'(n));
			local_in[n] = {(state == noc_pkg::HS_BUSY) && target[n], held};
		end
	end

	assign accepted = (state == noc_pkg::HS_BUSY) && |(target & local_ready);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= noc_pkg::HS_IDLE;
			inject_ack <= 1'b0;
		end
		else
		begin
			case (state)
				noc_pkg::HS_IDLE:
					if (inject_req)
						state <= noc_pkg::HS_BUSY;
				noc_pkg::HS_BUSY:
					if (accepted)
					begin
						inject_ack <= 1'b1;
						state <= noc_pkg::HS_WAIT_LOW;
					end
				default:
					if (!inject_req)
					begin
						inject_ack <= 1'b0;
						state <= noc_pkg::HS_IDLE;
					end
			endcase
		end
	end

	always_ff @(posedge clk)
		if (state == noc_pkg::HS_IDLE && inject_req)
			held <= inject_flit;

	// ack only answers a request that is still up
	assert property (@(posedge clk) disable iff (reset) $rose(inject_ack) |-> inject_req);

endmodule

`default_nettype wire

//--- rtl/noc_pkg.sv
// spidergon shared types
`default_nettype none

package noc_pkg;

	// largest ring this design supports
	localparam logic [4:0] MAX_NODES = 5'd16;

	localparam int NODE_ID_WIDTH = 4;
	localparam int PAYLOAD_WIDTH = 8;

	typedef logic [NODE_ID_WIDTH-1:0] node_id_t;

	// one packet is one flit
	typedef struct packed {
		node_id_t dest;
		node_id_t src;
		logic [PAYLOAD_WIDTH-1:0] payload;
	} flit_t;

	// forward half of a link, ready travels back separately
	typedef struct packed {
		logic valid;
		flit_t flit;
	} link_t;

	// port order matches the allocator input and output order
	typedef enum logic [1:0] {
		DIR_ACW,
		DIR_CW,
		DIR_ACROSS,
		DIR_LOCAL
	} port_dir_e;

	// four-phase req/ack handshake
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_BUSY,
		HS_WAIT_LOW
	} hs_state_e;

endpackage

`default_nettype wire

//--- rtl/spidergon_node.sv
// spidergon router node
`default_nettype none

module spidergon_node #(
	parameter int NUM_NODES = 8,
	parameter int FIFO_DEPTH = 4,
	parameter int NODE_ID = 0
) (
	input logic clk,
	input logic reset,
	input noc_pkg::link_t in_acw, in_cw, in_across,
	output logic ready_acw, ready_cw, ready_across,
	output logic bubble_acw, bubble_cw, bubble_across,
	output noc_pkg::link_t out_acw, out_cw, out_across,
	input logic down_ready_acw, down_ready_cw, down_ready_across,
	input logic down_bubble_acw, down_bubble_cw,
	input noc_pkg::link_t local_in,
	output logic local_ready,
	output noc_pkg::link_t eject_out,
	input logic eject_ready
);

	noc_pkg::link_t arrive [3];
	noc_pkg::link_t fifo_head [3];
	noc_pkg::link_t head [4];
	noc_pkg::port_dir_e req_dir [4];
	noc_pkg::flit_t req_flit [4];
	logic [2:0] fifo_ready, fifo_bubble;
	logic [3:0] req_valid, grant, room;

	// relative distance decides the next hop
	function automatic noc_pkg::port_dir_e route(input noc_pkg::node_id_t dest);
		int rel;
		rel = (int'(dest) + NUM_NODES - NODE_ID) % NUM_NODES;
		if (rel == 0)
			return noc_pkg::DIR_LOCAL;
		else if (rel <= NUM_NODES / 4)
			return noc_pkg::DIR_CW;
		else if (rel >= 3 * NUM_NODES / 4)
			return noc_pkg::DIR_ACW;
		return noc_pkg::DIR_ACROSS;
	endfunction

	assign arrive = '{in_acw, in_cw, in_across};

	for (genvar i = 0; i < 3; i++)
	begin : g_buf
		flit_fifo #(.NUM_NODES(NUM_NODES), .FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
			.clk(clk),
			.reset(reset),
			.wr_valid(arrive[i].valid && fifo_ready[i]),
			.wr_flit(arrive[i].flit),
			.rd_pop(grant[i]),
			.rd_head(fifo_head[i]),
			.ready(fifo_ready[i]),
			.bubble(fifo_bubble[i])
		);
	end

	assign {ready_across, ready_cw, ready_acw} = fifo_ready;
	assign {bubble_across, bubble_cw, bubble_acw} = fifo_bubble;
	assign local_ready = grant[noc_pkg::DIR_LOCAL];

	// an output stage has room when it is empty or drains this cycle
	assign room[noc_pkg::DIR_ACW] = !out_acw.valid || down_ready_acw;
	assign room[noc_pkg::DIR_CW] = !out_cw.valid || down_ready_cw;
	assign room[noc_pkg::DIR_ACROSS] = !out_across.valid || down_ready_across;
	assign room[noc_pkg::DIR_LOCAL] = !eject_out.valid || eject_ready;

	always_comb
	begin
		logic eligible;
		for (int i = 0; i < 3; i++)
			head[i] = fifo_head[i];
		head[3] = local_in;
		for (int i = 0; i < 4; i++)
		begin
			req_dir[i] = route(head[i].flit.dest);
			req_flit[i] = head[i].flit;
			// turning onto a ring needs two free slots, continuing needs one
			case (req_dir[i])
				noc_pkg::DIR_CW:
					eligible = room[noc_pkg::DIR_CW]
						&& (i == noc_pkg::DIR_ACW || down_bubble_cw);
				noc_pkg::DIR_ACW:
					eligible = room[noc_pkg::DIR_ACW]
						&& (i == noc_pkg::DIR_CW || down_bubble_acw);
				default:
					eligible = room[req_dir[i]];
			endcase
			req_valid[i] = head[i].valid && eligible;
		end
	end

	switch_allocator #(.NUM_NODES(NUM_NODES)) u_alloc (
		.clk(clk),
		.reset(reset),
		.req_dir(req_dir),
		.req_valid(req_valid),
		.req_flit(req_flit),
		.grant(grant),
		.out_acw(out_acw),
		.out_cw(out_cw),
		.out_across(out_across),
		.eject_out(eject_out),
		.out_hold(~room)
	);

	// traffic for this node always leaves through eject
	assert property (@(posedge clk) disable iff (reset)
		!(out_cw.valid && out_cw.flit.dest == NODE_ID)
		&& !(out_acw.valid && out_acw.flit.dest == NODE_ID)
		&& !(out_across.valid && out_across.flit.dest == NODE_ID));

endmodule

`default_nettype wire

//--- rtl/spidergon_top.sv
// spidergon network top
`default_nettype none

module spidergon_top #(
	parameter int NUM_NODES = 8,
	parameter int FIFO_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic inject_req,
	input noc_pkg::flit_t inject_flit,
	output logic inject_ack,
	output logic eject_req,
	output noc_pkg::flit_t eject_flit,
	input logic eject_ack
);

	noc_pkg::link_t local_in [NUM_NODES];
	noc_pkg::link_t eject_link [NUM_NODES];
	noc_pkg::link_t cw_link [NUM_NODES];
	noc_pkg::link_t acw_link [NUM_NODES];
	noc_pkg::link_t across_link [NUM_NODES];
	logic [NUM_NODES-1:0] local_ready;
	logic [NUM_NODES-1:0] eject_grant;
	logic [NUM_NODES-1:0] rdy_acw, rdy_cw, rdy_across;
	logic [NUM_NODES-1:0] bub_acw, bub_cw;

	initial
		assert (NUM_NODES % 4 == 0 && NUM_NODES <= int'(noc_pkg::MAX_NODES))
			else $fatal(1, "NUM_NODES must be a multiple of 4 up to MAX_NODES");

	injection_port #(.NUM_NODES(NUM_NODES)) u_inject (
		.clk(clk),
		.reset(reset),
		.inject_req(inject_req),
		.inject_flit(inject_flit),
		.inject_ack(inject_ack),
		.local_in(local_in),
		.local_ready(local_ready)
	);

	for (genvar i = 0; i < NUM_NODES; i++)
	begin : g_node
		localparam int PREV = (i + NUM_NODES - 1) % NUM_NODES;
		localparam int NEXT = (i + 1) % NUM_NODES;
		localparam int OPP = (i + NUM_NODES / 2) % NUM_NODES;

		spidergon_node #(
			.NUM_NODES(NUM_NODES),
			.FIFO_DEPTH(FIFO_DEPTH),
			.NODE_ID(i)
		) u_node (
			.clk(clk),
			.reset(reset),
			.in_acw(cw_link[PREV]),
			.in_cw(acw_link[NEXT]),
			.in_across(across_link[OPP]),
			.ready_acw(rdy_acw[i]),
			.ready_cw(rdy_cw[i]),
			.ready_across(rdy_across[i]),
			.bubble_acw(bub_acw[i]),
			.bubble_cw(bub_cw[i]),
			// nothing enters the across link as a ring, so no bubble is needed there
			.bubble_across(),
			.out_acw(acw_link[i]),
			.out_cw(cw_link[i]),
			.out_across(across_link[i]),
			.down_ready_acw(rdy_cw[PREV]),
			.down_ready_cw(rdy_acw[NEXT]),
			.down_ready_across(rdy_across[OPP]),
			.down_bubble_acw(bub_cw[PREV]),
			.down_bubble_cw(bub_acw[NEXT]),
			.local_in(local_in[i]),
			.local_ready(local_ready[i]),
			.eject_out(eject_link[i]),
			.eject_ready(eject_grant[i])
		);
	end

	ejection_port #(.NUM_NODES(NUM_NODES)) u_eject (
		.clk(clk),
		.reset(reset),
		.node_out(eject_link),
		.node_grant(eject_grant),
		.eject_req(eject_req),
		.eject_flit(eject_flit),
		.eject_ack(eject_ack)
	);

endmodule

`default_nettype wire

//--- rtl/switch_allocator.sv
// crossbar allocator with registered outputs
`default_nettype none

module switch_allocator #(
	parameter int NUM_NODES = 8
) (
	input logic clk,
	input logic reset,
	input noc_pkg::port_dir_e req_dir [4],
	input logic [3:0] req_valid,
	input noc_pkg::flit_t req_flit [4],
	output logic [3:0] grant,
	output noc_pkg::link_t out_acw,
	output noc_pkg::link_t out_cw,
	output noc_pkg::link_t out_across,
	output noc_pkg::link_t eject_out,
	input logic [3:0] out_hold
);

	// want[o][i] means input i asks for output o
	logic [3:0] want [4];
	logic [3:0] pick_valid;
	logic [1:0] pick [4];
	logic [1:0] rr [4];
	logic [3:0] out_valid;
	noc_pkg::flit_t out_flit [4];

	always_comb
	begin
		for (int o = 0; o < 4; o++)
			for (int i = 0; i < 4; i++)
				want[o][i] = req_valid[i] && (req_dir[i] == noc_pkg::port_dir_e'(o));
	end

	// rotating priority over the three link inputs with local injection last
	always_comb
	begin
		int idx;
		for (int o = 0; o < 4; o++)
		begin
			pick_valid[o] = want[o][3];
			pick[o] = 2'd3;
			for (int k = 2; k >= 0; k--)
			begin
				idx = (int'(rr[o]) + k) % 3;
				if (want[o][idx])
				begin
					pick_valid[o] = 1'b1;
					pick[o] = 2'(idx);
				end
			end
			if (out_hold[o])
				pick_valid[o] = 1'b0;
		end
	end

	always_comb
	begin
		grant = '0;
		for (int o = 0; o < 4; o++)
			if (pick_valid[o])
				grant[pick[o]] = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= '0;
			for (int o = 0; o < 4; o++)
				rr[o] <= '0;
		end
		else
		begin
			for (int o = 0; o < 4; o++)
				if (!out_hold[o])
				begin
					out_valid[o] <= pick_valid[o];
					if (pick_valid[o] && pick[o] != 2'd3)
						rr[o] <= (pick[o] == 2'd2) ? 2'd0 : pick[o] + 2'd1;
				end
		end
	end

	always_ff @(posedge clk)
		for (int o = 0; o < 4; o++)
			if (pick_valid[o])
				out_flit[o] <= req_flit[pick[o]];

	assign out_acw = {out_valid[noc_pkg::DIR_ACW], out_flit[noc_pkg::DIR_ACW]};
	assign out_cw = {out_valid[noc_pkg::DIR_CW], out_flit[noc_pkg::DIR_CW]};
	assign out_across = {out_valid[noc_pkg::DIR_ACROSS], out_flit[noc_pkg::DIR_ACROSS]};
	assign eject_out = {out_valid[noc_pkg::DIR_LOCAL], out_flit[noc_pkg::DIR_LOCAL]};

	for (genvar o = 0; o < 4; o++)
	begin : g_chk
		assert property (@(posedge clk) disable iff (reset) $onehot0(grant & want[o]));
		// only ring addresses sit in an output register
		assert property (@(posedge clk) disable iff (reset)
			out_valid[o] |-> out_flit[o].dest < NUM_NODES);
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the spidergon testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module spidergon_tb -f sources.f -o spidergon_sim

output=$(./obj_dir/spidergon_sim)
printf '%s\n' "$output"

# the run passes only if the testbench printed its pass line
printf '%s\n' "$output" | grep -qx 'sim passed'

//--- sources.f
+incdir+include
rtl/noc_pkg.sv
rtl/flit_fifo.sv
rtl/switch_allocator.sv
rtl/spidergon_node.sv
rtl/injection_port.sv
rtl/ejection_port.sv
rtl/spidergon_top.sv
tests/spidergon_tb.sv

//--- include/traffic_table.svh
// spidergon traffic table
`ifndef TRAFFIC_TABLE_SVH
`define TRAFFIC_TABLE_SVH

// each entry is {src, dest, payload} in hex, 4 + 4 + 8 bits
// the payload equals the entry index, so every ejected packet names its entry
// the expected ejection is the same src, dest and payload, exactly once
localparam int TABLE_LEN = 80;

localparam logic [15:0] TRAFFIC [TABLE_LEN] = '{
	// every rel 0 to 7 from each source on an 8 node ring
	16'h0000, 16'h0101, 16'h0202, 16'h0303,
	16'h0404, 16'h0505, 16'h0606, 16'h0707,
	16'h1108, 16'h1209, 16'h130a, 16'h140b,
	16'h150c, 16'h160d, 16'h170e, 16'h100f,
	16'h2210, 16'h2311, 16'h2412, 16'h2513,
	16'h2614, 16'h2715, 16'h2016, 16'h2117,
	16'h3318, 16'h3419, 16'h351a, 16'h361b,
	16'h371c, 16'h301d, 16'h311e, 16'h321f,
	16'h4420, 16'h4521, 16'h4622, 16'h4723,
	16'h4024, 16'h4125, 16'h4226, 16'h4327,
	16'h5528, 16'h5629, 16'h572a, 16'h502b,
	16'h512c, 16'h522d, 16'h532e, 16'h542f,
	16'h6630, 16'h6731, 16'h6032, 16'h6133,
	16'h6234, 16'h6335, 16'h6436, 16'h6537,
	16'h7738, 16'h7039, 16'h713a, 16'h723b,
	16'h733c, 16'h743d, 16'h753e, 16'h763f,
	// bursts on one pair: across then ring, clockwise, across, across then ring
	16'h2740, 16'h2741, 16'h2742, 16'h2743,
	16'h5644, 16'h5645, 16'h5646, 16'h5647,
	16'h0448, 16'h0449, 16'h044a, 16'h044b,
	16'h634c, 16'h634d, 16'h634e, 16'h634f
};

`endif

//--- tests/spidergon_tb.sv
// spidergon network testbench
`default_nettype none

module spidergon_tb;

	localparam int NUM_NODES = 8;
	localparam int FIFO_DEPTH = 4;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_ACK_DELAY = 15;
	localparam int DRAIN_CYCLES = 100;

	`include "traffic_table.svh"

	logic clk;
	logic reset;
	logic inject_req;
	noc_pkg::flit_t inject_flit;
	logic inject_ack;
	logic eject_req;
	noc_pkg::flit_t eject_flit;
	logic eject_ack;

	int seed;
	int value_errors;
	int protocol_errors;
	int delivery_errors;
	int delivered_count;
	logic [TABLE_LEN-1:0] injected;
	logic [TABLE_LEN-1:0] delivered;

	spidergon_top #(.NUM_NODES(NUM_NODES), .FIFO_DEPTH(FIFO_DEPTH)) UUT (
		.clk(clk),
		.reset(reset),
		.inject_req(inject_req),
		.inject_flit(inject_flit),
		.inject_ack(inject_ack),
		.eject_req(eject_req),
		.eject_flit(eject_flit),
		.eject_ack(eject_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// table entry is {src, dest, payload}
	function automatic noc_pkg::flit_t expected_flit(input int idx);
		noc_pkg::flit_t f;
		f.src = TRAFFIC[idx][15:12];
		f.dest = TRAFFIC[idx][11:8];
		f.payload = TRAFFIC[idx][7:0];
		return f;
	endfunction

	task automatic value_mismatch(input string name, input logic [15:0] exp,
		input logic [15:0] got);
		$display("Fail %s expected %h got %h", name, exp, got);
		value_errors++;
	endtask

	task automatic protocol_fault(input string msg);
		$display("%s at time %0t", msg, $time);
		protocol_errors++;
	endtask

	task automatic delivery_fault(input string msg);
		$display("%s", msg);
		delivery_errors++;
	endtask

	// lists every table entry that never came out
	task automatic report_missing();
		for (int i = 0; i < TABLE_LEN; i++)
			assert (delivered[i])
			else delivery_fault($sformatf("entry %0d was never delivered", i));
	endtask

	task automatic finish_run();
		$display("errors: %0d value, %0d protocol, %0d delivery, %0d of %0d packets delivered",
			value_errors, protocol_errors, delivery_errors, delivered_count, TABLE_LEN);
		if (value_errors + protocol_errors + delivery_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	// one four-phase transfer on the injection channel
	task automatic send_packet(input int idx);
		injected[idx] = 1'b1;
		inject_flit <= expected_flit(idx);
		inject_req <= 1'b1;
		do
			@(posedge clk);
		while (!inject_ack);
		inject_req <= 1'b0;
		do
			@(posedge clk);
		while (inject_ack);
	endtask

	// scoreboard for one ejected packet
	task automatic check_delivery(input noc_pkg::flit_t f);
		int idx;
		noc_pkg::flit_t exp;
		noc_pkg::flit_t prior;
		idx = int'(f.payload);
		assert (idx < TABLE_LEN)
		else delivery_fault($sformatf("extra packet with unknown payload %h", f.payload));
		if (idx < TABLE_LEN)
		begin
			exp = expected_flit(idx);
			assert (f.dest == exp.dest)
			else value_mismatch("eject_flit.dest", 16'(exp.dest), 16'(f.dest));
			assert (f.src == exp.src)
			else value_mismatch("eject_flit.src", 16'(exp.src), 16'(f.src));
			assert (injected[idx])
			else delivery_fault($sformatf("entry %0d came out before it was injected", idx));
			assert (!delivered[idx])
			else delivery_fault($sformatf("entry %0d was delivered twice", idx));
			// earlier packets of the same pair must already be out
			for (int j = 0; j < idx; j++)
			begin
				prior = expected_flit(j);
				if (prior.src == exp.src && prior.dest == exp.dest)
					assert (delivered[j])
					else delivery_fault($sformatf("entry %0d overtook entry %0d", idx, j));
			end
			if (!delivered[idx])
				delivered_count++;
			delivered[idx] = 1'b1;
		end
	endtask

	// ejection responder with random ack delay
	initial
	begin
		int delay;
		forever
		begin
			@(posedge clk);
			if (!reset && eject_req)
			begin
				check_delivery(eject_flit);
				delay = {$random(seed)} % (MAX_ACK_DELAY + 1);
				repeat (delay)
					@(posedge clk);
				eject_ack <= 1'b1;
				do
					@(posedge clk);
				while (eject_req);
				eject_ack <= 1'b0;
			end
		end
	end

	// four-phase rules on both channels checked once per edge
	initial
	begin
		logic prev_ireq;
		logic prev_iack;
		logic prev_ereq;
		logic prev_eack;
		noc_pkg::flit_t prev_eflit;
		prev_ireq = 1'b0;
		prev_iack = 1'b0;
		prev_ereq = 1'b0;
		prev_eack = 1'b0;
		prev_eflit = '0;
		forever
		begin
			@(posedge clk);
			if (!reset)
			begin
				assert (prev_iack || !inject_ack || inject_req)
				else protocol_fault("inject_ack rose while inject_req was low");
				assert (!prev_iack || inject_ack || !prev_ireq)
				else protocol_fault("inject_ack fell while inject_req was still high");
				assert (!(prev_ereq && eject_req) || eject_flit == prev_eflit)
				else value_mismatch("eject_flit", prev_eflit, eject_flit);
				assert (prev_ereq || !eject_req || !prev_eack)
				else protocol_fault("eject_req rose while eject_ack was still high");
				assert (!prev_ereq || eject_req || prev_eack)
				else protocol_fault("eject_req fell without eject_ack");
			end
			prev_ireq = inject_req;
			prev_iack = inject_ack;
			prev_ereq = eject_req;
			prev_eack = eject_ack;
			prev_eflit = eject_flit;
		end
	end

	// watchdog scaled by the table length
	initial
	begin
		repeat (RESET_CYCLES + TABLE_LEN * 200)
			@(posedge clk);
		delivery_fault("timeout, the traffic did not drain in time");
		report_missing();
		finish_run();
	end

	initial
	begin
		seed = 49;
		value_errors = 0;
		protocol_errors = 0;
		delivery_errors = 0;
		delivered_count = 0;
		injected = '0;
		delivered = '0;
		reset = 1'b1;
		inject_req = 1'b0;
		inject_flit = '0;
		eject_ack = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		assert (!inject_ack)
		else value_mismatch("inject_ack", 16'd0, 16'(inject_ack));
		assert (!eject_req)
		else value_mismatch("eject_req", 16'd0, 16'(eject_req));
		for (int i = 0; i < TABLE_LEN; i++)
			send_packet(i);
		while (delivered_count < TABLE_LEN)
			@(posedge clk);
		// quiet period so a late extra packet still shows up
		repeat (DRAIN_CYCLES)
			@(posedge clk);
		finish_run();
	end

endmodule

`default_nettype wire
